// ==== sib_macros.svh ====
// Build constants for the SampleInBall unit
// Values follow the ML-DSA parameter set with TAU = 39
// Changing TAU also changes the start index of the sampler
// Coefficients are stored in SIB_Q_W-1 bits, which holds Q-1

`ifndef SIB_MACROS_SVH
`define SIB_MACROS_SVH

// Prime modulus of the lattice ring
`define SIB_Q 8380417

// Width of arithmetic mod Q
`define SIB_Q_W 24

// Number of nonzero challenge coefficients
`define SIB_TAU 39

// Hash bytes consumed as sign bits before sampling starts
`define SIB_SIGN_BYTES 8

// Polynomial size and packing of the coefficient memory
`define SIB_COEFFS 256
`define SIB_WORD_COEFFS 4

`endif

// ==== sib_pkg.sv ====
// Shared types of the SampleInBall unit
// Widths derive from the macros header, so both must agree
// Stored coefficients hold only 0, 1 or Q-1

`default_nettype none

`include "sib_macros.svh"

package sib_pkg;

  // Index and address widths
  localparam int SIB_IDX_W  = $clog2(`SIB_COEFFS);
  localparam int SIB_SLOT_W = $clog2(`SIB_WORD_COEFFS);
  localparam int SIB_ADDR_W = SIB_IDX_W - SIB_SLOT_W;

  typedef logic [`SIB_Q_W-2:0] coeff_t;
  typedef coeff_t [`SIB_WORD_COEFFS-1:0] mem_word_t;
  typedef logic [SIB_ADDR_W-1:0] word_addr_t;
  typedef logic [SIB_IDX_W-1:0] sib_index_t;

  // Stored forms of +1 and -1
  localparam coeff_t COEFF_POS = coeff_t'(1);
  localparam coeff_t COEFF_NEG = coeff_t'(`SIB_Q - 1);

endpackage

`default_nettype wire

// ==== sib_coeff_mem.sv ====
// Flop-based coefficient memory, 64 words of four coefficients
// Two registered read/write ports serve the shuffler
// Reads return the word as it was before a write in the same cycle
// The two ports must not write one word in the same cycle
// clear_i zeroes every word in a single cycle

`default_nettype none

module sib_coeff_mem
  import sib_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst_b,
  input  wire logic             clear_i,

  // Shuffler ports
  input  wire logic [1:0]       we_i,
  input  wire word_addr_t [1:0] addr_i,
  input  wire mem_word_t [1:0]  wrdata_i,
  output mem_word_t [1:0]       rddata_o,

  // Readout port with one cycle of latency
  input  wire sib_index_t       rd_idx_i,
  output coeff_t                rd_coeff_o
);

  localparam int MEM_WORDS = 2 ** SIB_ADDR_W;

  mem_word_t             mem_q [MEM_WORDS];
  mem_word_t             rd_word_q;
  logic [SIB_SLOT_W-1:0] rd_slot_q;

  // Polynomial starts at zero after reset and after every clear
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (clear_i) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (we_i[p]) begin
          mem_q[addr_i[p]] <= wrdata_i[p];
        end
      end
    end
  end

  // Registered reads for both shuffler ports and the readout port
  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      rddata_o[p] <= mem_q[addr_i[p]];
    end
    rd_word_q <= mem_q[rd_idx_i[SIB_IDX_W-1:SIB_SLOT_W]];
    rd_slot_q <= rd_idx_i[SIB_SLOT_W-1:0];
  end

  // The slot select follows the registered word
  assign rd_coeff_o = rd_word_q[rd_slot_q];

  // A double write to one word would silently drop the port 0 data
  a_no_double_write : assert property (
    @(posedge clk) disable iff (!rst_b)
    !(we_i[0] && we_i[1] && (addr_i[0] == addr_i[1]))
  );

endmodule

`default_nettype wire

// ==== sample_in_ball_shuffler.sv ====
// Swaps coefficient j into slot i and writes the signed one at j
// Every request takes two cycles: a read cycle, then a write cycle
// The requester must keep valid and all request fields stable under hold
// Port 0 addresses the word of j and port 1 the word of i
// The memory must return read data one cycle after the address

`default_nettype none

module sample_in_ball_shuffler
  import sib_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_b,
  input  wire logic                  zeroize,

  // Swap request
  input  wire logic                  valid_i,
  output logic                       hold_o,
  input  wire sib_index_t            indexi_i,
  input  wire sib_index_t            indexj_i,
  input  wire logic                  sign_i,

  // Two read/write ports into the coefficient memory
  output logic       [1:0]           we_o,
  output word_addr_t [1:0]           addr_o,
  output mem_word_t  [1:0]           wrdata_o,
  input  wire mem_word_t [1:0]       rddata_i
);

  logic                  read_valid;
  logic                  addr_match;
  logic [SIB_SLOT_W-1:0] slot_i;
  logic [SIB_SLOT_W-1:0] slot_j;
  coeff_t                nxt_i;
  coeff_t                nxt_j;
  mem_word_t             word_i_upd;

  // First cycle of a request is the read cycle, so it is held
  assign hold_o = valid_i & ~read_valid;

  // Addresses stay on the ports for both cycles since the request is stable
  assign addr_o[0] = indexj_i[SIB_IDX_W-1:SIB_SLOT_W];
  assign addr_o[1] = indexi_i[SIB_IDX_W-1:SIB_SLOT_W];

  assign slot_i = indexi_i[SIB_SLOT_W-1:0];
  assign slot_j = indexj_i[SIB_SLOT_W-1:0];

  // Both indices in one word means one port must carry both updates
  assign addr_match = (addr_o[0] == addr_o[1]);

  // Marks the write cycle, which follows each read cycle
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      read_valid <= 1'b0;
    end else if (zeroize) begin
      read_valid <= 1'b0;
    end else begin
      read_valid <= valid_i & ~read_valid;
    end
  end

  // Slot j receives +1 or -1 in stored form
  assign nxt_j = sign_i ? COEFF_NEG : COEFF_POS;

  // Slot i receives the old value found at j
  assign nxt_i = rddata_i[0][slot_j];

  // Port 0 rewrites the word of j with the signed one in place
  always_comb begin
    wrdata_o[0]         = rddata_i[0];
    wrdata_o[0][slot_j] = nxt_j;
  end

  // Port 1 rewrites the word of i with the moved coefficient
  always_comb begin
    word_i_upd         = rddata_i[1];
    word_i_upd[slot_i] = nxt_i;
  end

  // On a shared word, slot j is patched on top of the port 1 data
  // When i equals j this leaves the signed one in the slot, as required
  always_comb begin
    wrdata_o[1] = word_i_upd;
    if (addr_match) begin
      wrdata_o[1][slot_j] = nxt_j;
    end
  end

  assign we_o[0] = read_valid & ~addr_match;
  assign we_o[1] = read_valid;

  // The requester keeps the request steady from the read into the write cycle
  a_request_stable_under_hold : assert property (
    @(posedge clk) disable iff (!rst_b || zeroize)
    (valid_i && hold_o) |=> (valid_i && $stable(indexi_i) && $stable(indexj_i)
                             && $stable(sign_i))
  );

endmodule

`default_nettype wire

// ==== sib_index_gen.sv ====
// Turns a stream of hash bytes into swap requests for the shuffler
// The first SIB_SIGN_BYTES bytes are sign bits, first byte in the low bits
// Later bytes are rejection-sampled against the running index i
// Reset, start and zeroize all leave it ready for a new run
// Bytes offered before a start are consumed as part of that run
// After TAU swaps done rises and all bytes are held

`default_nettype none

`include "sib_macros.svh"

module sib_index_gen
  import sib_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_b,
  input  wire logic        start_i,
  input  wire logic        zeroize_i,

  // Hash byte stream
  input  wire logic        byte_valid_i,
  input  wire logic [7:0]  byte_i,
  output logic             byte_hold_o,

  // Swap request to the shuffler
  output logic             req_valid_o,
  input  wire logic        req_hold_i,
  output sib_index_t       req_i_o,
  output sib_index_t       req_j_o,
  output logic             req_sign_o,

  output logic             done_o
);

  localparam int SIGN_W     = `SIB_SIGN_BYTES * 8;
  localparam int SIGN_CNT_W = $clog2(`SIB_SIGN_BYTES + 1);

  // First and last values of the running index
  localparam sib_index_t IDX_FIRST = sib_index_t'(`SIB_COEFFS - `SIB_TAU);
  localparam sib_index_t IDX_LAST  = sib_index_t'(`SIB_COEFFS - 1);

  logic [SIGN_W-1:0]     sign_q;
  logic [SIGN_CNT_W-1:0] sign_cnt_q;
  sib_index_t            idx_q;
  logic                  done_q;
  logic                  restart;
  logic                  sampling;
  logic                  accept;
  logic                  byte_take;
  logic                  req_done;

  assign restart = start_i | zeroize_i;

  // Sign collection ends once every sign byte is in
  assign sampling = (sign_cnt_q == SIGN_CNT_W'(`SIB_SIGN_BYTES));

  // Rejection rule: j must not exceed i
  assign accept = (sib_index_t'(byte_i) <= idx_q);

  // An accepted byte is the request itself, so the source keeps it stable
  assign req_valid_o = sampling & byte_valid_i & accept & ~done_q & ~restart;
  assign req_i_o     = idx_q;
  assign req_j_o     = sib_index_t'(byte_i);
  assign req_sign_o  = sign_q[0];

  assign req_done = req_valid_o & ~req_hold_i;

  // Hold bytes during a restart, after done, and while the swap reads
  assign byte_hold_o = restart | done_q | (req_valid_o & req_hold_i);

  assign byte_take = byte_valid_i & ~byte_hold_o;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      sign_q     <= '0;
      sign_cnt_q <= '0;
      idx_q      <= IDX_FIRST;
      done_q     <= 1'b0;
    end else if (restart) begin
      sign_q     <= '0;
      sign_cnt_q <= '0;
      idx_q      <= IDX_FIRST;
      done_q     <= 1'b0;
    end else if (!sampling) begin
      // New sign byte enters at the top and moves down one byte per load
      if (byte_take) begin
        sign_q     <= {byte_i, sign_q[SIGN_W-1:8]};
        sign_cnt_q <= sign_cnt_q + 1'b1;
      end
    end else if (req_done) begin
      // Each finished swap uses up one sign bit
      sign_q <= sign_q >> 1;
      if (idx_q == IDX_LAST) begin
        done_q <= 1'b1;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  assign done_o = done_q;

  // A held byte stays on the input until it is taken, since it is the request
  a_byte_stable_under_hold : assert property (
    @(posedge clk) disable iff (!rst_b || restart)
    (byte_valid_i && byte_hold_o) |=> (byte_valid_i && $stable(byte_i))
  );

endmodule

`default_nettype wire

// ==== sample_in_ball.sv ====
// SampleInBall top level: index generator, shuffler and memory
// Hash bytes arrive on a valid strobe with a hold level for back-pressure
// Run length depends on how many bytes are rejected
// Coefficients read back as 0, 1 or Q-1 with one cycle of latency

`default_nettype none

module sample_in_ball
  import sib_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_b,
  input  wire logic       start_i,
  input  wire logic       zeroize_i,
  input  wire logic       byte_valid_i,
  input  wire logic [7:0] byte_i,
  output logic            byte_hold_o,
  output logic            done_o,
  input  wire sib_index_t rd_idx_i,
  output coeff_t          rd_coeff_o
);

  // Request path
  logic       req_valid;
  logic       req_hold;
  sib_index_t req_i;
  sib_index_t req_j;
  logic       req_sign;

  // Memory ports
  logic       [1:0] mem_we;
  word_addr_t [1:0] mem_addr;
  mem_word_t  [1:0] mem_wrdata;
  mem_word_t  [1:0] mem_rddata;

  // Start and zeroize both wipe the polynomial and abort a swap
  logic mem_clear;
  assign mem_clear = start_i | zeroize_i;

  sib_index_gen u_index_gen (
    .clk          (clk),
    .rst_b        (rst_b),
    .start_i      (start_i),
    .zeroize_i    (zeroize_i),
    .byte_valid_i (byte_valid_i),
    .byte_i       (byte_i),
    .byte_hold_o  (byte_hold_o),
    .req_valid_o  (req_valid),
    .req_hold_i   (req_hold),
    .req_i_o      (req_i),
    .req_j_o      (req_j),
    .req_sign_o   (req_sign),
    .done_o       (done_o)
  );

  sample_in_ball_shuffler u_shuffler (
    .clk      (clk),
    .rst_b    (rst_b),
    .zeroize  (mem_clear),
    .valid_i  (req_valid),
    .hold_o   (req_hold),
    .indexi_i (req_i),
    .indexj_i (req_j),
    .sign_i   (req_sign),
    .we_o     (mem_we),
    .addr_o   (mem_addr),
    .wrdata_o (mem_wrdata),
    .rddata_i (mem_rddata)
  );

  sib_coeff_mem u_coeff_mem (
    .clk        (clk),
    .rst_b      (rst_b),
    .clear_i    (mem_clear),
    .we_i       (mem_we),
    .addr_i     (mem_addr),
    .wrdata_i   (mem_wrdata),
    .rddata_o   (mem_rddata),
    .rd_idx_i   (rd_idx_i),
    .rd_coeff_o (rd_coeff_o)
  );

endmodule

`default_nettype wire

// ==== tb_sample_in_ball.sv ====
// Directed testbench for the SampleInBall top level
// A software model rebuilds the challenge polynomial from the same byte list
// Inputs change 2 time units after each rising clock edge
// Outputs are sampled 2 units after the edge or at the falling edge

`default_nettype none

`include "sib_macros.svh"

module tb_sample_in_ball
  import sib_pkg::*;
();

  localparam int NUM_TESTS    = 5;
  localparam int CYCLE_BUDGET = NUM_TESTS * (8 + 4 * 256 * 2 + 300);
  localparam int FIRST_I      = `SIB_COEFFS - `SIB_TAU;

  logic       clk;
  logic       rst_b;
  logic       start_i;
  logic       zeroize_i;
  logic       byte_valid_i;
  logic [7:0] byte_i;
  logic       byte_hold_o;
  logic       done_o;
  sib_index_t rd_idx_i;
  coeff_t     rd_coeff_o;

  integer     seed;
  int         error_count;
  int         check_count;
  int         hold_cycles;
  logic [7:0] stim [0:1023];
  int         stim_len;
  coeff_t     exp_c [`SIB_COEFFS];
  coeff_t     got_c [`SIB_COEFFS];

  sample_in_ball u_sample_in_ball (
    .clk          (clk),
    .rst_b        (rst_b),
    .start_i      (start_i),
    .zeroize_i    (zeroize_i),
    .byte_valid_i (byte_valid_i),
    .byte_i       (byte_i),
    .byte_hold_o  (byte_hold_o),
    .done_o       (done_o),
    .rd_idx_i     (rd_idx_i),
    .rd_coeff_o   (rd_coeff_o)
  );

  always #10 clk = ~clk;

  // Moves to the drive point of the next cycle
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic check_coeff(input sib_index_t idx, input coeff_t got, input coeff_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] t=%0t rd_coeff_o[%0d] got %0h expected %0h", $time, idx, got, exp);
    end
  endtask

  task automatic check_done(input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] t=%0t done_o got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    error_count++;
    $display("Error at t=%0t: %s", $time, what);
  endtask

  // Builds sign bytes and data bytes; forced mode adds rejections and same-word pairs
  task automatic build_stimulus(input bit forced);
    int         i;
    int         r;
    logic [7:0] b;
    stim_len = 0;
    for (int k = 0; k < `SIB_SIGN_BYTES; k++) begin
      stim[stim_len] = $random(seed);
      stim_len++;
    end
    i = FIRST_I;
    while (i < `SIB_COEFFS) begin
      r = $random(seed) & 32'h7fffffff;
      if (forced) begin
        // A byte above i must be dropped by the sampler
        if (i < `SIB_COEFFS - 1 && r[8]) begin
          stim[stim_len] = i + 1 + (r % (`SIB_COEFFS - 1 - i));
          stim_len++;
        end
        // Even i takes a j from its own word, odd i any j up to i
        if (i % 2 == 0) b = (i & 8'hfc) | (r % ((i & 3) + 1));
        else            b = r % (i + 1);
        stim[stim_len] = b;
        stim_len++;
        i++;
      end else begin
        b = r[7:0];
        stim[stim_len] = b;
        stim_len++;
        if (b <= i) i++;
      end
    end
  endtask

  // Reference SampleInBall: move c[j] to c[i], then put the signed one at j
  task automatic compute_model();
    logic [63:0] signs;
    int          i;
    int          j;
    int          k;
    int          p;
    for (int c = 0; c < `SIB_COEFFS; c++) exp_c[c] = '0;
    for (int b = 0; b < `SIB_SIGN_BYTES; b++) signs[8*b +: 8] = stim[b];
    i = FIRST_I;
    k = 0;
    p = `SIB_SIGN_BYTES;
    while (i < `SIB_COEFFS && p < stim_len) begin
      j = stim[p];
      p++;
      if (j <= i) begin
        exp_c[i] = exp_c[j];
        exp_c[j] = signs[k] ? coeff_t'(`SIB_Q - 1) : coeff_t'(1);
        i++;
        k++;
      end
    end
    if (i != `SIB_COEFFS || p != stim_len) report_error("byte list does not end on the last swap");
  endtask

  // Offers one byte and keeps it stable until the DUT takes it
  task automatic send_byte(input logic [7:0] b);
    bit taken;
    taken        = 1'b0;
    byte_valid_i = 1'b1;
    byte_i       = b;
    while (!taken) begin
      @(negedge clk);
      taken = !byte_hold_o;
      if (!taken) hold_cycles++;
      step();
    end
    byte_valid_i = 1'b0;
  endtask

  task automatic feed_bytes(input int first, input int last, input bit gaps);
    for (int p = first; p < last; p++) begin
      if (gaps && ($random(seed) & 1)) step();
      send_byte(stim[p]);
    end
  endtask

  task automatic pulse_start();
    start_i = 1'b1;
    step();
    start_i = 1'b0;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (!done_o && n < 100) begin
      step();
      n++;
    end
    if (!done_o) report_error("done_o never rose after the last byte");
  endtask

  task automatic read_all_coeffs();
    for (int idx = 0; idx < `SIB_COEFFS; idx++) begin
      rd_idx_i = sib_index_t'(idx);
      step();
      got_c[idx] = rd_coeff_o;
    end
  endtask

  // Compares with the model, then counts and classifies the nonzero entries
  task automatic check_against_model();
    int nonzero;
    nonzero = 0;
    read_all_coeffs();
    for (int idx = 0; idx < `SIB_COEFFS; idx++) begin
      check_coeff(sib_index_t'(idx), got_c[idx], exp_c[idx]);
      if (got_c[idx] != '0) begin
        nonzero++;
        if (got_c[idx] != coeff_t'(1) && got_c[idx] != coeff_t'(`SIB_Q - 1))
          report_error($sformatf("coefficient %0d is neither +1 nor -1", idx));
      end
    end
    if (nonzero != `SIB_TAU)
      report_error($sformatf("found %0d nonzero coefficients instead of %0d",
                             nonzero, `SIB_TAU));
  endtask

  task automatic check_all_zero();
    read_all_coeffs();
    for (int idx = 0; idx < `SIB_COEFFS; idx++) check_coeff(sib_index_t'(idx), got_c[idx], '0);
  endtask

  // One full run; every accepted byte sees exactly one held cycle
  task automatic run_and_check(input bit forced);
    build_stimulus(forced);
    compute_model();
    pulse_start();
    check_done(done_o, 1'b0);
    hold_cycles = 0;
    feed_bytes(0, `SIB_SIGN_BYTES, forced);
    check_done(done_o, 1'b0);
    feed_bytes(`SIB_SIGN_BYTES, stim_len, forced);
    wait_done();
    check_done(done_o, 1'b1);
    if (hold_cycles != `SIB_TAU)
      report_error($sformatf("saw %0d held byte cycles instead of %0d",
                             hold_cycles, `SIB_TAU));
    check_against_model();
  endtask

  task automatic test_reset_state();
    check_done(done_o, 1'b0);
    check_count++;
    if (byte_hold_o !== 1'b0) begin
      error_count++;
      $display("[FAIL] t=%0t byte_hold_o got %b expected %b", $time, byte_hold_o, 1'b0);
    end
  endtask

  task automatic test_restart_clears();
    check_done(done_o, 1'b1);
    pulse_start();
    check_done(done_o, 1'b0);
    check_all_zero();
  endtask

  task automatic test_zeroize_mid_run();
    build_stimulus(1'b0);
    pulse_start();
    feed_bytes(0, `SIB_SIGN_BYTES + 12, 1'b0);
    zeroize_i = 1'b1;
    step();
    check_done(done_o, 1'b0);
    step();
    zeroize_i = 1'b0;
    check_done(done_o, 1'b0);
    check_all_zero();
    run_and_check(1'b0);
  endtask

  // Stops a stuck run well after the longest expected test sequence
  initial begin
    repeat (CYCLE_BUDGET) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", CYCLE_BUDGET);
    $display("Verification failed");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst_b        = 1'b0;
    start_i      = 1'b0;
    zeroize_i    = 1'b0;
    byte_valid_i = 1'b0;
    byte_i       = '0;
    rd_idx_i     = '0;
    seed         = 32'h4b03729f;
    error_count  = 0;
    check_count  = 0;
    hold_cycles  = 0;
    repeat (2) @(posedge clk);
    #2;
    rst_b = 1'b1;
    test_reset_state();
    run_and_check(1'b0);
    run_and_check(1'b1);
    test_restart_clears();
    test_zeroize_mid_run();
    $display("Summary: %0d errors in %0d checks", error_count, check_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sample_in_ball.f ====
+incdir+.
sib_pkg.sv
sib_coeff_mem.sv
sample_in_ball_shuffler.sv
sib_index_gen.sv
sample_in_ball.sv
tb_sample_in_ball.sv
